// File: decodeStage.f
+incdir+hdl
hdl/riscvIsaPkg.sv
hdl/decodePkg.sv
hdl/instrLatch.sv
hdl/fieldGenerator.sv
hdl/controlDecoder.sv
hdl/registerFile.sv
hdl/decodeRegister.sv
hdl/decodeStage.sv
tests/decodeStage_props.sv
tests/decodeStage_tb.sv

// File: hdl/controlDecoder.sv
`timescale 1ns/1ps

module controlDecoder (
    input  riscvIsaPkg::instrWord   instruction,
    output decodePkg::controlBundle control
);
    import riscvIsaPkg::*;

    opcodeKind opcode;

    assign opcode = opcodeKind'(instruction[6:0]);

    always_comb begin
        control = '0;
        case (opcode)
            opRType: begin
                control.regWrite = 1'b1;
            end
            opLoad: begin
                control.regWrite     = 1'b1;
                control.memRead      = 1'b1;
                control.useImmediate = 1'b1;
            end
            opImm: begin
                control.regWrite     = 1'b1;
                control.useImmediate = 1'b1;
            end
            opJalr: begin
                control.regWrite     = 1'b1;
                control.jump         = 1'b1;
                control.useImmediate = 1'b1;    // Target from rs1 + imm
            end
            opBranch: begin
                control.branch     = 1'b1;
                control.pcRelative = 1'b1;
            end
            opStore: begin
                control.memWrite     = 1'b1;
                control.useImmediate = 1'b1;
            end
            opJal: begin
                control.regWrite   = 1'b1;
                control.jump       = 1'b1;
                control.pcRelative = 1'b1;
            end
            opAuipc: begin
                control.regWrite     = 1'b1;
                control.useImmediate = 1'b1;
                control.pcRelative   = 1'b1;
            end
            default: begin
                control.illegal = 1'b1;         // Nothing else set
            end
        endcase
    end

endmodule

// File: hdl/decodePkg.sv
package decodePkg;

    // Instruction as captured at the stage input
    typedef struct packed {
        riscvIsaPkg::word pc;
        riscvIsaPkg::instrWord instruction;
        riscvIsaPkg::word linkAddress;      // pc + 4
    } fetchBundle;

    // Fields split out of the instruction word
    typedef struct packed {
        riscvIsaPkg::regIndex ra;
        riscvIsaPkg::regIndex rb;
        riscvIsaPkg::regIndex rw;
        riscvIsaPkg::funct3Field funct3;
        riscvIsaPkg::funct7Field funct7;
        riscvIsaPkg::word immediate;        // Already sign-extended
    } fieldBundle;

    typedef struct packed {
        logic regWrite;
        logic memRead;
        logic memWrite;
        logic branch;
        logic jump;
        logic useImmediate;
        logic pcRelative;
        logic illegal;
    } controlBundle;

    // Registered result of the stage
    typedef struct packed {
        fieldBundle fields;
        controlBundle control;
        riscvIsaPkg::word readDataA;
        riscvIsaPkg::word readDataB;
        riscvIsaPkg::word linkAddress;
        riscvIsaPkg::word targetAddress;
    } decodedInstr;

endpackage

// File: hdl/decodeRegister.sv
`timescale 1ns/1ps

module decodeRegister (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    latchedValid,
    input  decodePkg::fetchBundle   fetched,
    input  decodePkg::fieldBundle   fields,
    input  decodePkg::controlBundle control,
    input  riscvIsaPkg::word        readDataA,
    input  riscvIsaPkg::word        readDataB,
    output decodePkg::decodedInstr  decoded,
    output logic                    decodedValid
);

    always_ff @(posedge clock) begin
        if (reset) begin
            decoded      <= '0;
            decodedValid <= 1'b0;
        end else begin
            decodedValid <= latchedValid;
            if (latchedValid) begin
                decoded.fields        <= fields;
                decoded.control       <= control;
                decoded.readDataA     <= readDataA;
                decoded.readDataB     <= readDataB;
                decoded.linkAddress   <= fetched.linkAddress;
                // Branch, JAL and AUIPC target
                decoded.targetAddress <= fetched.pc + fields.immediate;
            end
        end
    end

endmodule

// File: hdl/decodeStage.sv
`timescale 1ns/1ps

module decodeStage (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   instrValid,
    input  riscvIsaPkg::instrWord  instruction,
    input  riscvIsaPkg::word       pc,
    input  logic                   writeEnable,
    input  riscvIsaPkg::regIndex   writeIndex,
    input  riscvIsaPkg::word       writeData,
    output decodePkg::decodedInstr decoded,
    output logic                   decodedValid
);
    import riscvIsaPkg::*;
    import decodePkg::*;

    fetchBundle fetched;
    logic latchedValid;
    fieldBundle fields;
    controlBundle control;
    word readDataA;
    word readDataB;

    instrLatch latch (
        .clock        (clock),
        .reset        (reset),
        .instrValid   (instrValid),
        .instruction  (instruction),
        .pc           (pc),
        .fetched      (fetched),
        .latchedValid (latchedValid)
    );

    fieldGenerator generator (
        .instruction (fetched.instruction),
        .fields      (fields)
    );

    controlDecoder decoder (
        .instruction (fetched.instruction),
        .control     (control)
    );

    registerFile regFile (
        .clock       (clock),
        .reset       (reset),
        .readIndexA  (fields.ra),
        .readIndexB  (fields.rb),
        .writeEnable (writeEnable),
        .writeIndex  (writeIndex),
        .writeData   (writeData),
        .readDataA   (readDataA),
        .readDataB   (readDataB)
    );

    decodeRegister outputRegister (
        .clock        (clock),
        .reset        (reset),
        .latchedValid (latchedValid),
        .fetched      (fetched),
        .fields       (fields),
        .control      (control),
        .readDataA    (readDataA),
        .readDataB    (readDataB),
        .decoded      (decoded),
        .decodedValid (decodedValid)
    );

endmodule

// File: hdl/decode_defs.svh
`ifndef DECODE_DEFS_SVH
`define DECODE_DEFS_SVH

// Datapath and address width
`define XLEN 32

// Architectural register file
`define REG_COUNT 32
`define REG_INDEX_W 5

`endif

// File: hdl/fieldGenerator.sv
`timescale 1ns/1ps

module fieldGenerator (
    input  riscvIsaPkg::instrWord instruction,
    output decodePkg::fieldBundle fields
);
    import riscvIsaPkg::*;

    opcodeKind opcode;
    logic signed [11:0] immI;
    logic signed [11:0] immS;
    logic signed [12:0] immB;
    logic signed [20:0] immJ;

    assign opcode = opcodeKind'(instruction[6:0]);

    // Raw immediates per format, bit 31 is always the sign
    assign immI = instruction[31:20];
    assign immS = {instruction[31:25], instruction[11:7]};
    assign immB = {instruction[31], instruction[7], instruction[30:25],
                   instruction[11:8], 1'b0};
    assign immJ = {instruction[31], instruction[19:12], instruction[20],
                   instruction[30:21], 1'b0};

    always_comb begin
        fields = '0;    // Unused fields and unknown opcodes read as zero
        case (opcode)
            opRType: begin
                fields.ra     = instruction[19:15];
                fields.rb     = instruction[24:20];
                fields.rw     = instruction[11:7];
                fields.funct3 = instruction[14:12];
                fields.funct7 = instruction[31:25];
            end
            opLoad, opImm, opJalr: begin
                fields.ra        = instruction[19:15];
                fields.rw        = instruction[11:7];
                fields.funct3    = instruction[14:12];
                fields.immediate = word'(immI);
            end
            opStore: begin
                fields.ra        = instruction[19:15];
                fields.rb        = instruction[24:20];
                fields.funct3    = instruction[14:12];
                fields.immediate = word'(immS);
            end
            opBranch: begin
                fields.ra        = instruction[19:15];
                fields.rb        = instruction[24:20];
                fields.funct3    = instruction[14:12];
                fields.immediate = word'(immB);
            end
            opJal: begin
                fields.rw        = instruction[11:7];
                fields.immediate = word'(immJ);
            end
            opAuipc: begin
                fields.rw        = instruction[11:7];
                // Upper 20 bits, low 12 bits zero
                fields.immediate = word'(signed'({instruction[31:12], 12'b0}));
            end
            default: begin
            end
        endcase
    end

endmodule

// File: hdl/instrLatch.sv
`timescale 1ns/1ps

module instrLatch (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  instrValid,
    input  riscvIsaPkg::instrWord instruction,
    input  riscvIsaPkg::word      pc,
    output decodePkg::fetchBundle fetched,
    output logic                  latchedValid
);
    import riscvIsaPkg::*;

    always_ff @(posedge clock) begin
        if (reset) begin
            fetched      <= '0;
            latchedValid <= 1'b0;
        end else begin
            latchedValid <= instrValid;     // One-cycle pulse follows the strobe
            if (instrValid) begin
                fetched.pc          <= pc;
                fetched.instruction <= instruction;
                fetched.linkAddress <= pc + word'(4);
            end
        end
    end

endmodule

// File: hdl/registerFile.sv
`timescale 1ns/1ps
`include "decode_defs.svh"

module registerFile (
    input  logic                 clock,
    input  logic                 reset,
    input  riscvIsaPkg::regIndex readIndexA,
    input  riscvIsaPkg::regIndex readIndexB,
    input  logic                 writeEnable,
    input  riscvIsaPkg::regIndex writeIndex,
    input  riscvIsaPkg::word     writeData,
    output riscvIsaPkg::word     readDataA,
    output riscvIsaPkg::word     readDataB
);
    import riscvIsaPkg::*;

    word regs [`REG_COUNT];     // Entry 0 always reads as zero

    // Read port with write-through bypass
    function automatic word readPort(input regIndex index);
        if (index == '0) begin
            return '0;
        end
        if (writeEnable && writeIndex == index) begin
            return writeData;
        end
        return regs[index];
    endfunction

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && writeIndex != '0) begin
            regs[writeIndex] <= writeData;
        end
    end

    // Also sensitive to the array and the write port inside readPort
    always_comb readDataA = readPort(readIndexA);
    always_comb readDataB = readPort(readIndexB);

endmodule

// File: hdl/riscvIsaPkg.sv
`include "decode_defs.svh"

package riscvIsaPkg;

    typedef logic [`XLEN-1:0] word;         // Data or address
    typedef logic [31:0] instrWord;
    typedef logic [`REG_INDEX_W-1:0] regIndex;

    typedef logic [2:0] funct3Field;
    typedef logic [6:0] funct7Field;

    // Major opcodes handled by decode, LUI not included
    typedef enum logic [6:0] {
        opRType  = 7'b0110011,
        opLoad   = 7'b0000011,
        opImm    = 7'b0010011,
        opJalr   = 7'b1100111,
        opBranch = 7'b1100011,
        opStore  = 7'b0100011,
        opJal    = 7'b1101111,
        opAuipc  = 7'b0010111
    } opcodeKind;

endpackage

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
    -f decodeStage.f --top-module decodeStage_tb > build.log 2>&1 \
    && ./obj_dir/VdecodeStage_tb > sim.log 2>&1 \
    || echo "Build or simulation returned an error"
cat sim.log 2>/dev/null
grep -q "Simulation completed successfully" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: tests/decodeStage_props.sv
`timescale 1ns/1ps

module decodeStage_props (
    input logic clock,
    input logic reset,
    input logic instrValid,
    input logic decodedValid
);

    // Output strobe cleared by reset
    assert property (@(posedge clock) reset |=> !decodedValid)
        else $error("decodedValid high after a reset edge");

    // Two-cycle latency, checked in both directions
    assert property (@(posedge clock) disable iff (reset)
        $past(instrValid, 2) |-> decodedValid)
        else $error("decodedValid missing two cycles after instrValid");

    assert property (@(posedge clock) disable iff (reset)
        decodedValid |-> $past(instrValid, 2))
        else $error("decodedValid without instrValid two cycles earlier");

    // Single-cycle pulse unless a second instruction followed
    assert property (@(posedge clock) disable iff (reset)
        decodedValid && !$past(instrValid) |=> !decodedValid)
        else $error("decodedValid held longer than one cycle");

endmodule

bind decodeStage decodeStage_props props (
    .clock        (clock),
    .reset        (reset),
    .instrValid   (instrValid),
    .decodedValid (decodedValid)
);

// File: tests/decodeStage_tb.sv
`timescale 1ns/1ps
`include "decode_defs.svh"

module decodeStage_tb;
    import riscvIsaPkg::*;
    import decodePkg::*;

    // regWrite memRead memWrite branch, jump useImmediate pcRelative illegal
    localparam controlBundle ctlRType   = 8'b1000_0000;
    localparam controlBundle ctlLoad    = 8'b1100_0100;
    localparam controlBundle ctlImm     = 8'b1000_0100;
    localparam controlBundle ctlJalr    = 8'b1000_1100;
    localparam controlBundle ctlBranch  = 8'b0001_0010;
    localparam controlBundle ctlStore   = 8'b0010_0100;
    localparam controlBundle ctlJal     = 8'b1000_1010;
    localparam controlBundle ctlAuipc   = 8'b1000_0110;
    localparam controlBundle ctlIllegal = 8'b0000_0001;

    logic clock;
    logic reset;
    logic instrValid;
    instrWord instruction;
    word pc;
    logic writeEnable;
    regIndex writeIndex;
    word writeData;
    decodedInstr decoded;
    logic decodedValid;

    word model [`REG_COUNT];    // Expected register contents
    word rngState = 32'd72;

    decodeStage dut (.*);

    always #20 clock = ~clock;

    function automatic word nextRandom();
        rngState ^= rngState << 13;
        rngState ^= rngState >> 17;
        rngState ^= rngState << 5;
        return rngState;
    endfunction

    function automatic fieldBundle fieldsOf(regIndex a, regIndex b, regIndex w,
                                            funct3Field f3, funct7Field f7, word imm);
        return '{ra: a, rb: b, rw: w, funct3: f3, funct7: f7, immediate: imm};
    endfunction

    // Instruction encoders, one per format
    function automatic instrWord encR(funct7Field f7, regIndex rs2, regIndex rs1,
                                      funct3Field f3, regIndex rd);
        return {f7, rs2, rs1, f3, rd, opRType};
    endfunction

    function automatic instrWord encI(word imm, regIndex rs1, funct3Field f3, regIndex rd,
                                      opcodeKind op);
        return {imm[11:0], rs1, f3, rd, op};
    endfunction

    function automatic instrWord encS(word imm, regIndex rs2, regIndex rs1, funct3Field f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], opStore};
    endfunction

    function automatic instrWord encB(word imm, regIndex rs2, regIndex rs1, funct3Field f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opBranch};
    endfunction

    function automatic instrWord encJ(word imm, regIndex rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opJal};
    endfunction

    function automatic instrWord encU(word imm, regIndex rd);
        return {imm[31:12], rd, opAuipc};
    endfunction

    task automatic nextCycle();
        @(posedge clock);
        #2;
    endtask

    task automatic stopWithError(input string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic compareFields(input string name, input fieldBundle expected,
                                 input fieldBundle actual);
        if (actual !== expected) begin
            stopWithError($sformatf("Fail %s fields: expected %h, actual %h",
                                    name, expected, actual));
        end
    endtask

    task automatic compareControl(input string name, input controlBundle expected,
                                  input controlBundle actual);
        if (actual !== expected) begin
            stopWithError($sformatf("Fail %s control: expected %b, actual %b",
                                    name, expected, actual));
        end
    endtask

    task automatic compareWord(input string name, input word expected, input word actual);
        if (actual !== expected) begin
            stopWithError($sformatf("Fail %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    task automatic applyReset();
        reset = 1'b1;
        repeat (2) @(posedge clock);
        #2;
        reset = 1'b0;
        for (int i = 0; i < `REG_COUNT; i++) begin
            model[i] = '0;
        end
    endtask

    task automatic writeReg(input regIndex index, input word data);
        writeEnable = 1'b1;
        writeIndex  = index;
        writeData   = data;
        nextCycle();
        writeEnable = 1'b0;
        if (index != '0) begin
            model[index] = data;    // x0 stays zero
        end
    endtask

    task automatic issue(input instrWord instr, input word pcValue);
        instrValid  = 1'b1;
        instruction = instr;
        pc          = pcValue;
        nextCycle();
        instrValid  = 1'b0;
    endtask

    task automatic waitDecoded(input string name);
        int cycles;
        cycles = 0;
        while (!decodedValid && cycles < 10) begin
            nextCycle();
            cycles++;
        end
        if (!decodedValid) begin
            stopWithError($sformatf("No output strobe arrived for %s within 10 cycles", name));
        end
    endtask

    task automatic checkDecoded(input string name, input word pcValue,
                                input fieldBundle expFields, input controlBundle expControl);
        compareFields(name, expFields, decoded.fields);
        compareControl(name, expControl, decoded.control);
        compareWord({name, " readDataA"}, model[expFields.ra], decoded.readDataA);
        compareWord({name, " readDataB"}, model[expFields.rb], decoded.readDataB);
        compareWord({name, " link"}, pcValue + 4, decoded.linkAddress);
        compareWord({name, " target"}, pcValue + expFields.immediate, decoded.targetAddress);
    endtask

    task automatic runCase(input string name, input instrWord instr, input word pcValue,
                           input fieldBundle expFields, input controlBundle expControl);
        issue(instr, pcValue);
        waitDecoded(name);
        checkDecoded(name, pcValue, expFields, expControl);
    endtask

    task automatic testRType();
        word pcVal;
        for (int i = 1; i < `REG_COUNT; i++) begin
            writeReg(regIndex'(i), nextRandom());
        end
        pcVal = nextRandom() & ~word'(3);
        runCase("rType sub", encR(7'h20, 5'd17, 5'd5, 3'd0, 5'd9), pcVal,
                fieldsOf(5'd5, 5'd17, 5'd9, 3'd0, 7'h20, '0), ctlRType);
        runCase("rType and", encR(7'h00, 5'd31, 5'd1, 3'd7, 5'd31), pcVal + 4,
                fieldsOf(5'd1, 5'd31, 5'd31, 3'd7, 7'h00, '0), ctlRType);
    endtask

    task automatic testIType();
        word r;
        word imm;
        r = nextRandom();
        imm = word'($signed(r[11:0]));
        runCase("load negative", encI(-4, 5'd3, 3'd2, 5'd7, opLoad), 32'h0000_1000,
                fieldsOf(5'd3, 5'd0, 5'd7, 3'd2, 7'd0, -4), ctlLoad);
        runCase("addi max", encI(2047, 5'd8, 3'd0, 5'd8, opImm), 32'h0000_2000,
                fieldsOf(5'd8, 5'd0, 5'd8, 3'd0, 7'd0, 2047), ctlImm);
        runCase("addi min", encI(-2048, 5'd2, 3'd4, 5'd6, opImm), 32'h0000_2004,
                fieldsOf(5'd2, 5'd0, 5'd6, 3'd4, 7'd0, -2048), ctlImm);
        runCase("addi random", encI(imm, 5'd11, 3'd6, 5'd12, opImm), 32'h0000_2008,
                fieldsOf(5'd11, 5'd0, 5'd12, 3'd6, 7'd0, imm), ctlImm);
        runCase("jalr", encI(-16, 5'd1, 3'd0, 5'd1, opJalr), 32'h0000_3000,
                fieldsOf(5'd1, 5'd0, 5'd1, 3'd0, 7'd0, -16), ctlJalr);
    endtask

    task automatic testStoreBranch();
        runCase("store", encS(-100, 5'd12, 5'd4, 3'd2), 32'h0000_4000,
                fieldsOf(5'd4, 5'd12, 5'd0, 3'd2, 7'd0, -100), ctlStore);
        runCase("branch back", encB(-8, 5'd6, 5'd5, 3'd0), 32'h0000_4010,
                fieldsOf(5'd5, 5'd6, 5'd0, 3'd0, 7'd0, -8), ctlBranch);
        runCase("branch forward", encB(4094, 5'd20, 5'd21, 3'd5), 32'h0000_4020,
                fieldsOf(5'd21, 5'd20, 5'd0, 3'd5, 7'd0, 4094), ctlBranch);
    endtask

    task automatic testJalAuipc();
        word pcVal;
        pcVal = nextRandom() & ~word'(3);
        runCase("jal back", encJ(-4660, 5'd1), pcVal,
                fieldsOf(5'd0, 5'd0, 5'd1, 3'd0, 7'd0, -4660), ctlJal);
        runCase("jal forward", encJ(1048574, 5'd5), pcVal + 8,
                fieldsOf(5'd0, 5'd0, 5'd5, 3'd0, 7'd0, 1048574), ctlJal);
        runCase("auipc", encU(32'hABCD_E000, 5'd10), pcVal + 16,
                fieldsOf(5'd0, 5'd0, 5'd10, 3'd0, 7'd0, 32'hABCD_E000), ctlAuipc);
    endtask

    task automatic testRegisterFile();
        word value;
        word pcVal;
        pcVal = 32'h0000_5000;
        writeReg(5'd0, 32'hFFFF_FFFF);
        runCase("x0 write", encR(7'd0, 5'd17, 5'd0, 3'd0, 5'd3), pcVal,
                fieldsOf(5'd0, 5'd17, 5'd3, 3'd0, 7'd0, '0), ctlRType);
        // Write lands in the cycle the instruction sits in the latch
        value = nextRandom();
        issue(encI(16, 5'd12, 3'd0, 5'd13, opImm), pcVal + 4);
        writeEnable = 1'b1;
        writeIndex  = 5'd12;
        writeData   = value;
        nextCycle();
        writeEnable = 1'b0;
        model[12] = value;
        waitDecoded("bypass");
        checkDecoded("bypass", pcVal + 4, fieldsOf(5'd12, 5'd0, 5'd13, 3'd0, 7'd0, 16), ctlImm);
        applyReset();
        runCase("after reset", encR(7'd0, 5'd17, 5'd12, 3'd0, 5'd9), pcVal + 8,
                fieldsOf(5'd12, 5'd17, 5'd9, 3'd0, 7'd0, '0), ctlRType);
    endtask

    task automatic testIllegalAndPipeline();
        word r;
        word pcVal;
        r = nextRandom();
        pcVal = nextRandom() & ~word'(3);
        runCase("illegal lui", {r[31:7], 7'b0110111}, pcVal, '0, ctlIllegal);
        issue(encI(100, 5'd2, 3'd0, 5'd4, opImm), pcVal);
        issue(encB(-64, 5'd4, 5'd2, 3'd1), pcVal + 4);
        waitDecoded("pipeline first");
        checkDecoded("pipeline first", pcVal, fieldsOf(5'd2, 5'd0, 5'd4, 3'd0, 7'd0, 100), ctlImm);
        nextCycle();
        if (!decodedValid) begin
            stopWithError("Second back-to-back result did not arrive on the next cycle");
        end
        checkDecoded("pipeline second", pcVal + 4,
                     fieldsOf(5'd2, 5'd4, 5'd0, 3'd1, 7'd0, -64), ctlBranch);
    endtask

    initial begin
        clock       = 1'b0;
        reset       = 1'b1;
        instrValid  = 1'b0;
        instruction = '0;
        pc          = '0;
        writeEnable = 1'b0;
        writeIndex  = '0;
        writeData   = '0;
        applyReset();
        testRType();
        testIType();
        testStoreBranch();
        testJalAuipc();
        testRegisterFile();
        testIllegalAndPipeline();
        $display("Simulation completed successfully");
        $finish;
    end

endmodule
